/* compile.f */
+incdir+logic
logic/isaPkg.sv
logic/controlPkg.sv
logic/ALUDecoder.sv
logic/controlUnit.sv
logic/immExtend.sv
logic/regFile.sv
logic/decodeStage.sv
sim/decodeStage_assertions.sv
sim/decodeChecker.sv
sim/decodeStage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
simBinary=VdecodeStage_tb

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module decodeStage_tb -Mdir "$buildDir" -o "$simBinary" -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Simulation passed" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

/* sim/decodeStage_tb.sv */
`include "riscv_macros.svh"

module decodeStage_tb import isaPkg::*, controlPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TestCycles = 2000;
    localparam int ResetCycles = 3;
    localparam int TimeoutCycles = TestCycles + ResetCycles + 497;
    localparam logic [31:0] Seed = 32'h2bc7_21ea;

    logic clk;
    logic reset;
    logic [`DATA_WIDTH-1:0] InstrD;
    logic [`DATA_WIDTH-1:0] PCD;
    logic FlushE;
    logic RegWriteW;
    logic [`REG_ADDR_WIDTH-1:0] RdW;
    logic [`DATA_WIDTH-1:0] ResultW;
    logic RegWriteE;
    resultSrcT ResultSrcE;
    logic MemWriteE;
    logic MemReadE;
    logic JumpE;
    logic BranchE;
    aluControlT ALUControlE;
    logic ALUSrcE;
    modeBUT modeBUE;
    logic [`DATA_WIDTH-1:0] RD1E;
    logic [`DATA_WIDTH-1:0] RD2E;
    logic [`DATA_WIDTH-1:0] ImmExtE;
    logic [`DATA_WIDTH-1:0] PCE;
    logic [`REG_ADDR_WIDTH-1:0] Rs1E;
    logic [`REG_ADDR_WIDTH-1:0] Rs2E;
    logic [`REG_ADDR_WIDTH-1:0] RdE;
    int checkErrors;
    int assertErrors;
    int cycleCount;

    decodeStage DUT (
        .clk(clk), .reset(reset), .InstrD(InstrD), .PCD(PCD), .FlushE(FlushE),
        .RegWriteW(RegWriteW), .RdW(RdW), .ResultW(ResultW),
        .RegWriteE(RegWriteE), .ResultSrcE(ResultSrcE), .MemWriteE(MemWriteE),
        .MemReadE(MemReadE), .JumpE(JumpE), .BranchE(BranchE),
        .ALUControlE(ALUControlE), .ALUSrcE(ALUSrcE), .modeBUE(modeBUE),
        .RD1E(RD1E), .RD2E(RD2E), .ImmExtE(ImmExtE), .PCE(PCE),
        .Rs1E(Rs1E), .Rs2E(Rs2E), .RdE(RdE)
    );

    decodeChecker scoreboard (
        .clk(clk), .reset(reset), .InstrD(InstrD), .PCD(PCD), .FlushE(FlushE),
        .RegWriteW(RegWriteW), .RdW(RdW), .ResultW(ResultW),
        .RegWriteE(RegWriteE), .ResultSrcE(ResultSrcE), .MemWriteE(MemWriteE),
        .MemReadE(MemReadE), .JumpE(JumpE), .BranchE(BranchE),
        .ALUControlE(ALUControlE), .ALUSrcE(ALUSrcE), .modeBUE(modeBUE),
        .RD1E(RD1E), .RD2E(RD2E), .ImmExtE(ImmExtE), .PCE(PCE),
        .Rs1E(Rs1E), .Rs2E(Rs2E), .RdE(RdE), .errorCount(checkErrors)
    );

    function automatic logic isValidOpcode(input logic [6:0] op);
        return op inside {opR, opI, opLoad, opStore, opBranch, opLui, opAuipc, opJal, opJalr};
    endfunction

    function automatic logic [6:0] randomOpcode();
        logic [6:0] op;
        case ($urandom_range(0, 9))
            0: op = opR;
            1: op = opI;
            2: op = opLoad;
            3: op = opStore;
            4: op = opBranch;
            5: op = opLui;
            6: op = opAuipc;
            7: op = opJal;
            8: op = opJalr;
            default: begin
                op = 7'($urandom);
                while (isValidOpcode(op))
                    op = 7'($urandom);
            end
        endcase
        return op;
    endfunction

    task automatic driveRandomCycle();
        logic [31:0] instr;
        instr = $urandom;
        instr[6:0] = randomOpcode();
        InstrD = instr;
        PCD = PCD + 32'd4;
        FlushE = ($urandom_range(0, 15) == 0);
        RegWriteW = 1'($urandom_range(0, 1));
        RdW = 5'($urandom_range(0, 31));
        if ($urandom_range(0, 3) == 0)
            RdW = instr[19:15]; // Exercise the write-through path
        ResultW = $urandom;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run hung: no end of test after %0d cycles", TimeoutCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(Seed));
        reset = 1'b1;
        InstrD = '0;
        PCD = '0;
        FlushE = 1'b0;
        RegWriteW = 1'b0;
        RdW = '0;
        ResultW = '0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (TestCycles) begin
            driveRandomCycle();
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk); // Assertions on the last flush have reported by now
        assertErrors = DUT.assertChecks.failCount;
        $display("Checked %0d cycles: %0d compare errors, %0d assertion failures",
                 TestCycles, checkErrors, assertErrors);
        if (checkErrors == 0 && assertErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim/decodeChecker.sv */
`include "riscv_macros.svh"

module decodeChecker import isaPkg::*, controlPkg::*; (
    input logic clk,
    input logic reset,
    input logic [`DATA_WIDTH-1:0] InstrD,
    input logic [`DATA_WIDTH-1:0] PCD,
    input logic FlushE,
    input logic RegWriteW,
    input logic [`REG_ADDR_WIDTH-1:0] RdW,
    input logic [`DATA_WIDTH-1:0] ResultW,
    input logic RegWriteE,
    input resultSrcT ResultSrcE,
    input logic MemWriteE,
    input logic MemReadE,
    input logic JumpE,
    input logic BranchE,
    input aluControlT ALUControlE,
    input logic ALUSrcE,
    input modeBUT modeBUE,
    input logic [`DATA_WIDTH-1:0] RD1E,
    input logic [`DATA_WIDTH-1:0] RD2E,
    input logic [`DATA_WIDTH-1:0] ImmExtE,
    input logic [`DATA_WIDTH-1:0] PCE,
    input logic [`REG_ADDR_WIDTH-1:0] Rs1E,
    input logic [`REG_ADDR_WIDTH-1:0] Rs2E,
    input logic [`REG_ADDR_WIDTH-1:0] RdE,
    output int errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`DATA_WIDTH-1:0] modelRegs [0:`REG_COUNT-1];
    logic predValid = 1'b0;
    int errors = 0;

    // Expected E-stage register contents
    logic expRegWrite;
    logic expMemWrite;
    logic expMemRead;
    logic expJump;
    logic expBranch;
    logic expALUSrc;
    resultSrcT expResultSrc;
    aluControlT expALUControl;
    modeBUT expModeBU;
    logic [`DATA_WIDTH-1:0] expRD1;
    logic [`DATA_WIDTH-1:0] expRD2;
    logic [`DATA_WIDTH-1:0] expImm;
    logic [`DATA_WIDTH-1:0] expPC;
    logic [`REG_ADDR_WIDTH-1:0] expRs1;
    logic [`REG_ADDR_WIDTH-1:0] expRs2;
    logic [`REG_ADDR_WIDTH-1:0] expRd;

    assign errorCount = errors;

    function automatic logic [`DATA_WIDTH-1:0] readModelReg(input logic [4:0] addr);
        if (addr == '0)
            return '0;
        if (RegWriteW && RdW == addr)
            return ResultW; // Same-cycle writeback
        return modelRegs[addr];
    endfunction

    function automatic aluControlT expectedAluControl(input logic [31:0] instr);
        logic [2:0] f3;
        f3 = instr[14:12];
        if (instr[6:0] == opR || instr[6:0] == opI) begin
            case (f3)
                3'b000: return (instr[5] && instr[30]) ? aluSub : aluAdd;
                3'b001: return aluSll;
                3'b010: return aluSlt;
                3'b011: return aluSltu;
                3'b100: return aluXor;
                3'b101: return instr[30] ? aluSra : aluSrl;
                3'b110: return aluOr;
                default: return aluAnd;
            endcase
        end
        if (instr[6:0] == opBranch) begin
            if (f3 == 3'b100 || f3 == 3'b101)
                return aluSlt;
            if (f3 == 3'b110 || f3 == 3'b111)
                return aluSltu;
            return aluSub;
        end
        return aluAdd;
    endfunction

    function automatic logic [31:0] expectedImmediate(input logic [31:0] instr);
        case (instr[6:0])
            opI, opLoad, opJalr: return {{20{instr[31]}}, instr[31:20]};
            opStore: return {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch: return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opLui, opAuipc: return {instr[31:12], 12'h000};
            opJal: return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic modeBUT expectedAccessMode(input logic [31:0] instr);
        logic isLoad;
        isLoad = (instr[6:0] == opLoad);
        if (!isLoad && instr[6:0] != opStore)
            return buNone;
        case (instr[14:12])
            3'b000: return buByte;
            3'b001: return buHalf;
            3'b010: return buWord;
            3'b100: return isLoad ? buByteU : buNone;
            3'b101: return isLoad ? buHalfU : buNone;
            default: return buNone;
        endcase
    endfunction

    task automatic predictControl(input logic [6:0] op);
        expRegWrite = 1'b0;
        expMemWrite = 1'b0;
        expMemRead = 1'b0;
        expJump = 1'b0;
        expBranch = 1'b0;
        expALUSrc = 1'b0;
        expResultSrc = resAlu;
        case (op)
            opR: expRegWrite = 1'b1;
            opI, opLui, opAuipc: begin
                expRegWrite = 1'b1;
                expALUSrc = 1'b1;
            end
            opLoad: begin
                expRegWrite = 1'b1;
                expMemRead = 1'b1;
                expALUSrc = 1'b1;
                expResultSrc = resMem;
            end
            opStore: begin
                expMemWrite = 1'b1;
                expALUSrc = 1'b1;
            end
            opBranch: expBranch = 1'b1;
            opJal, opJalr: begin
                expRegWrite = 1'b1;
                expJump = 1'b1;
                expALUSrc = (op == opJalr);
                expResultSrc = resPc4;
            end
            default: expResultSrc = resNone; // Invalid opcode
        endcase
    endtask

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (reset || FlushE) begin
            predictControl(7'h00);
            expResultSrc = resAlu; // Bubble, not an invalid instruction
            expALUControl = aluAdd;
            expModeBU = buNone;
            expRD1 = '0;
            expRD2 = '0;
            expImm = '0;
            expPC = '0;
            expRs1 = '0;
            expRs2 = '0;
            expRd = '0;
        end else begin
            predictControl(InstrD[6:0]);
            expALUControl = expectedAluControl(InstrD);
            expModeBU = expectedAccessMode(InstrD);
            expRD1 = readModelReg(InstrD[19:15]);
            expRD2 = readModelReg(InstrD[24:20]);
            expImm = expectedImmediate(InstrD);
            expPC = PCD;
            expRs1 = InstrD[19:15];
            expRs2 = InstrD[24:20];
            expRd = InstrD[11:7];
        end
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                modelRegs[i] = '0;
        end else if (RegWriteW && RdW != '0) begin
            modelRegs[RdW] = ResultW;
        end
        predValid = 1'b1;
    end

    // Outputs settle half a period after the edge
    always @(negedge clk) begin
        if (predValid) begin
            checkField("RegWriteE", 32'(expRegWrite), 32'(RegWriteE));
            checkField("ResultSrcE", 32'(expResultSrc), 32'(ResultSrcE));
            checkField("MemWriteE", 32'(expMemWrite), 32'(MemWriteE));
            checkField("MemReadE", 32'(expMemRead), 32'(MemReadE));
            checkField("JumpE", 32'(expJump), 32'(JumpE));
            checkField("BranchE", 32'(expBranch), 32'(BranchE));
            checkField("ALUControlE", 32'(expALUControl), 32'(ALUControlE));
            checkField("ALUSrcE", 32'(expALUSrc), 32'(ALUSrcE));
            checkField("modeBUE", 32'(expModeBU), 32'(modeBUE));
            checkField("RD1E", expRD1, RD1E);
            checkField("RD2E", expRD2, RD2E);
            checkField("ImmExtE", expImm, ImmExtE);
            checkField("PCE", expPC, PCE);
            checkField("Rs1E", 32'(expRs1), 32'(Rs1E));
            checkField("Rs2E", 32'(expRs2), 32'(Rs2E));
            checkField("RdE", 32'(expRd), 32'(RdE));
        end
    end

endmodule

/* sim/decodeStage_assertions.sv */
module decodeStage_assertions import controlPkg::*; (
    input logic clk,
    input logic reset,
    input logic FlushE,
    input logic RegWriteE,
    input logic MemWriteE,
    input logic MemReadE,
    input logic JumpE,
    input logic BranchE,
    input modeBUT modeBUE
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0; // Read by the testbench at the end of the run

    bubbleAfterClear: assert property (@(posedge clk)
        (reset || FlushE) |=> !RegWriteE && !MemWriteE && !MemReadE && !JumpE && !BranchE
            && modeBUE == buNone)
    else begin
        failCount = failCount + 1;
        $error("Execute controls still active one cycle after reset or flush");
    end

    memAccessExclusive: assert property (@(posedge clk) disable iff (reset)
        !(MemWriteE && MemReadE))
    else begin
        failCount = failCount + 1;
        $error("Load and store both active in execute");
    end

    jumpBranchExclusive: assert property (@(posedge clk) disable iff (reset)
        !(JumpE && BranchE))
    else begin
        failCount = failCount + 1;
        $error("Jump and branch both active in execute");
    end

endmodule

bind decodeStage decodeStage_assertions assertChecks (
    .clk(clk),
    .reset(reset),
    .FlushE(FlushE),
    .RegWriteE(RegWriteE),
    .MemWriteE(MemWriteE),
    .MemReadE(MemReadE),
    .JumpE(JumpE),
    .BranchE(BranchE),
    .modeBUE(modeBUE)
);

/* logic/decodeStage.sv */
`include "riscv_macros.svh"

module decodeStage import controlPkg::*; (
    input logic clk,
    input logic reset,
    input logic [`DATA_WIDTH-1:0] InstrD,
    input logic [`DATA_WIDTH-1:0] PCD,
    input logic FlushE,
    input logic RegWriteW,
    input logic [`REG_ADDR_WIDTH-1:0] RdW,
    input logic [`DATA_WIDTH-1:0] ResultW,
    output logic RegWriteE,
    output resultSrcT ResultSrcE,
    output logic MemWriteE,
    output logic MemReadE,
    output logic JumpE,
    output logic BranchE,
    output aluControlT ALUControlE,
    output logic ALUSrcE,
    output modeBUT modeBUE,
    output logic [`DATA_WIDTH-1:0] RD1E,
    output logic [`DATA_WIDTH-1:0] RD2E,
    output logic [`DATA_WIDTH-1:0] ImmExtE,
    output logic [`DATA_WIDTH-1:0] PCE,
    output logic [`REG_ADDR_WIDTH-1:0] Rs1E,
    output logic [`REG_ADDR_WIDTH-1:0] Rs2E,
    output logic [`REG_ADDR_WIDTH-1:0] RdE
);
    localparam int PayloadWidth = 4 * `DATA_WIDTH + 3 * `REG_ADDR_WIDTH;

    logic [`REG_ADDR_WIDTH-1:0] Rs1D;
    logic [`REG_ADDR_WIDTH-1:0] Rs2D;
    logic [`REG_ADDR_WIDTH-1:0] RdD;
    logic RegWriteD;
    logic MemWriteD;
    logic MemReadD;
    logic JumpD;
    logic BranchD;
    logic ALUSrcD;
    resultSrcT ResultSrcD;
    aluControlT ALUControlD;
    immSrcT ImmSrcD;
    modeBUT modeBUD;
    logic [`DATA_WIDTH-1:0] RD1D;
    logic [`DATA_WIDTH-1:0] RD2D;
    logic [`DATA_WIDTH-1:0] ImmExtD;
    logic [PayloadWidth-1:0] payloadE; // Operands, immediate, PC and register indices

    assign Rs1D = InstrD[19:15];
    assign Rs2D = InstrD[24:20];
    assign RdD = InstrD[11:7];

    controlUnit ctrl (
        .InstrD(InstrD),
        .ResultSrcD(ResultSrcD),
        .MemWriteD(MemWriteD),
        .JumpD(JumpD),
        .BranchD(BranchD),
        .ALUControlD(ALUControlD),
        .ALUSrcD(ALUSrcD),
        .ImmSrcD(ImmSrcD),
        .RegWriteD(RegWriteD),
        .modeBUD(modeBUD),
        .MemReadD(MemReadD)
    );

    immExtend immExt (
        .Instr(InstrD[`DATA_WIDTH-1:7]),
        .ImmSrc(ImmSrcD),
        .ImmExt(ImmExtD)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .A1(Rs1D),
        .A2(Rs2D),
        .A3(RdW),
        .WE3(RegWriteW),
        .WD3(ResultW),
        .RD1(RD1D),
        .RD2(RD2D)
    );

    always_ff @(posedge clk) begin
        if (reset || FlushE) begin // Bubble into execute
            RegWriteE <= 1'b0;
            ResultSrcE <= resAlu;
            MemWriteE <= 1'b0;
            MemReadE <= 1'b0;
            JumpE <= 1'b0;
            BranchE <= 1'b0;
            ALUControlE <= aluAdd;
            ALUSrcE <= 1'b0;
            modeBUE <= buNone;
            payloadE <= '0;
        end else begin
            RegWriteE <= RegWriteD;
            ResultSrcE <= ResultSrcD;
            MemWriteE <= MemWriteD;
            MemReadE <= MemReadD;
            JumpE <= JumpD;
            BranchE <= BranchD;
            ALUControlE <= ALUControlD;
            ALUSrcE <= ALUSrcD;
            modeBUE <= modeBUD;
            payloadE <= {RD1D, RD2D, ImmExtD, PCD, Rs1D, Rs2D, RdD};
        end
    end

    assign {RD1E, RD2E, ImmExtE, PCE, Rs1E, Rs2E, RdE} = payloadE;

endmodule

/* logic/regFile.sv */
`include "riscv_macros.svh"

module regFile (
    input logic clk,
    input logic reset,
    input logic [`REG_ADDR_WIDTH-1:0] A1,
    input logic [`REG_ADDR_WIDTH-1:0] A2,
    input logic [`REG_ADDR_WIDTH-1:0] A3,
    input logic WE3,
    input logic [`DATA_WIDTH-1:0] WD3,
    output logic [`DATA_WIDTH-1:0] RD1,
    output logic [`DATA_WIDTH-1:0] RD2
);
    logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1]; // x0 has no storage

    function automatic logic [`DATA_WIDTH-1:0] readPort(input logic [`REG_ADDR_WIDTH-1:0] addr);
        if (addr == '0)
            return '0;
        else if (WE3 && A3 == addr)
            return WD3; // Writeback bypass
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (WE3 && A3 != '0) begin
            regs[A3] <= WD3;
        end
    end

    always_comb begin
        RD1 = readPort(A1);
        RD2 = readPort(A2);
    end

endmodule

/* logic/immExtend.sv */
`include "riscv_macros.svh"

module immExtend import controlPkg::*; (
    input logic [`DATA_WIDTH-1:7] Instr,
    input immSrcT ImmSrc,
    output logic [`DATA_WIDTH-1:0] ImmExt
);
    logic sign;

    assign sign = Instr[`DATA_WIDTH-1];

    always_comb begin
        case (ImmSrc)
            immI, immJalr: ImmExt = {{(`DATA_WIDTH-12){sign}}, Instr[31:20]};
            immS: ImmExt = {{(`DATA_WIDTH-12){sign}}, Instr[31:25], Instr[11:7]};
            immB: ImmExt = {{(`DATA_WIDTH-12){sign}}, Instr[7], Instr[30:25],
                            Instr[11:8], 1'b0};
            immU: ImmExt = {Instr[31:12], 12'b0};
            immJ: ImmExt = {{(`DATA_WIDTH-20){sign}}, Instr[19:12], Instr[20],
                            Instr[30:21], 1'b0};
            default: ImmExt = '0; // immNone
        endcase
    end

endmodule

/* logic/controlUnit.sv */
`include "riscv_macros.svh"

module controlUnit import isaPkg::*, controlPkg::*; (
    input logic [`DATA_WIDTH-1:0] InstrD,
    output resultSrcT ResultSrcD,
    output logic MemWriteD,
    output logic JumpD,
    output logic BranchD,
    output aluControlT ALUControlD,
    output logic ALUSrcD,
    output immSrcT ImmSrcD,
    output logic RegWriteD,
    output modeBUT modeBUD,
    output logic MemReadD
);
    opcodeT opcode;
    loadStoreFunct3T memFunct3;
    aluOpT ALUOp;
    logic valid;

    assign opcode = opcodeT'(InstrD[6:0]);
    assign memFunct3 = loadStoreFunct3T'(InstrD[14:12]);

    assign valid = opcode inside {opR, opI, opLoad, opStore, opBranch,
                                  opLui, opAuipc, opJal, opJalr};
    assign MemWriteD = (opcode == opStore);
    assign MemReadD = (opcode == opLoad);
    assign BranchD = (opcode == opBranch);
    assign JumpD = opcode inside {opJal, opJalr};
    assign RegWriteD = valid && !MemWriteD && !BranchD;
    assign ALUSrcD = opcode inside {opI, opLoad, opStore, opLui, opAuipc, opJalr};

    assign ResultSrcD = !valid ? resNone : MemReadD ? resMem : JumpD ? resPc4 : resAlu;
    assign ALUOp = (opcode inside {opR, opI}) ? aluOpFunct :
                   BranchD ? aluOpBranch :
                   (opcode == opJal) ? aluOpJump : aluOpAdd;

    always_comb begin
        case (opcode)
            opI, opLoad: ImmSrcD = immI;
            opStore: ImmSrcD = immS;
            opBranch: ImmSrcD = immB;
            opLui, opAuipc: ImmSrcD = immU;
            opJal: ImmSrcD = immJ;
            opJalr: ImmSrcD = immJalr;
            default: ImmSrcD = immNone; // R type and invalid
        endcase
    end

    always_comb begin
        modeBUD = buNone;
        if (MemReadD || MemWriteD) begin
            case (memFunct3)
                f3Byte: modeBUD = buByte;
                f3Half: modeBUD = buHalf;
                f3Word: modeBUD = buWord;
                f3ByteU: modeBUD = MemReadD ? buByteU : buNone; // No unsigned stores
                f3HalfU: modeBUD = MemReadD ? buHalfU : buNone;
                default: modeBUD = buNone;
            endcase
        end
    end

    ALUDecoder aluDecoder (
        .ALUOp(ALUOp),
        .op5(InstrD[5]),
        .funct3(InstrD[14:12]),
        .funct7(InstrD[30]),
        .ALUControl(ALUControlD)
    );

endmodule

/* logic/ALUDecoder.sv */
module ALUDecoder import controlPkg::*; (
    input aluOpT ALUOp,
    input logic op5,
    input logic [2:0] funct3,
    input logic funct7,
    output aluControlT ALUControl
);

    always_comb begin
        case (ALUOp)
            aluOpBranch: begin
                case (funct3)
                    3'b100, 3'b101: ALUControl = aluSlt; // blt, bge
                    3'b110, 3'b111: ALUControl = aluSltu; // bltu, bgeu
                    default: ALUControl = aluSub; // beq, bne
                endcase
            end
            aluOpFunct: begin
                case (funct3)
                    3'b000: ALUControl = (op5 && funct7) ? aluSub : aluAdd; // addi never subtracts
                    3'b001: ALUControl = aluSll;
                    3'b010: ALUControl = aluSlt;
                    3'b011: ALUControl = aluSltu;
                    3'b100: ALUControl = aluXor;
                    3'b101: ALUControl = funct7 ? aluSra : aluSrl;
                    3'b110: ALUControl = aluOr;
                    default: ALUControl = aluAnd;
                endcase
            end
            default: ALUControl = aluAdd; // Address and link arithmetic
        endcase
    end

endmodule

/* logic/controlPkg.sv */
package controlPkg;

    typedef enum logic [1:0] {
        aluOpAdd    = 2'b00,
        aluOpBranch = 2'b01,
        aluOpFunct  = 2'b10,
        aluOpJump   = 2'b11
    } aluOpT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluSll  = 4'b0010,
        aluSlt  = 4'b0011,
        aluSltu = 4'b0100,
        aluXor  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluOr   = 4'b1000,
        aluAnd  = 4'b1001
    } aluControlT;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ, immJalr,
        immNone = 3'b111
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu, resMem, resPc4, resNone
    } resultSrcT;

    // Access size seen by the byte unit in the memory stage
    typedef enum logic [2:0] {
        buNone, buWord, buHalf, buByte, buHalfU, buByteU
    } modeBUT;

endpackage

/* logic/isaPkg.sv */
package isaPkg;

    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    // Width field of loads and stores
    typedef enum logic [2:0] {
        f3Byte  = 3'b000,
        f3Half  = 3'b001,
        f3Word  = 3'b010,
        f3ByteU = 3'b100,
        f3HalfU = 3'b101
    } loadStoreFunct3T;

endpackage

/* logic/riscv_macros.svh */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define DATA_WIDTH 32
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

`endif
